//--- branch_alu.sv
`timescale 1ns/10ps

module branch_alu (
  input  logic                        clk,
  input  logic                        reset,

  input  logic                        iss_valid,
  output logic                        iss_ready,
  input  spu_branch_pkg::issue_req_t   iss_req,

  output logic                        alu_valid,
  input  logic                        alu_ready,
  output spu_branch_pkg::branch_res_t  alu_res
);

  import spu_branch_pkg::*;

  logic [0:pc_width-1]   seq_pc;
  logic [0:pc_width-1]   rel_pc;
  logic [0:pc_width-1]   abs_pc;
  logic [0:data_width-1] link_word;
  branch_res_t           res_d;
  logic                  iss_fire;

  // ********************************************************************
  // candidate targets
  // ********************************************************************

  assign seq_pc = iss_req.req.pc + 1'b1;  // wraps at 1024
  assign rel_pc = iss_req.req.pc + iss_req.req.imm16[imm_width-pc_width:imm_width-1];
  assign abs_pc = iss_req.req.imm16[imm_width-pc_width:imm_width-1];

  // return address in low bits of word 0
  always_comb begin
    link_word = '0;
    link_word[word_width-pc_width:word_width-1] = seq_pc;
  end

  // ********************************************************************
  // branch decode
  // ********************************************************************

  always_comb begin
    res_d = '0;
    case (iss_req.req.op)
      op_br: begin
        res_d.taken   = 1'b1;
        res_d.next_pc = rel_pc;
      end
      op_bra: begin
        res_d.taken   = 1'b1;
        res_d.next_pc = abs_pc;
      end
      op_brsl: begin
        res_d.taken     = 1'b1;
        res_d.next_pc   = rel_pc;
        res_d.link      = 1'b1;
        res_d.link_data = link_word;
      end
      op_brasl: begin
        res_d.taken     = 1'b1;
        res_d.next_pc   = abs_pc;
        res_d.link      = 1'b1;
        res_d.link_data = link_word;
      end
      op_brz: begin
        res_d.taken   = iss_req.word0_zero;
        res_d.next_pc = iss_req.word0_zero ? rel_pc : seq_pc;
      end
      op_brnz: begin
        res_d.taken   = !iss_req.word0_zero;
        res_d.next_pc = !iss_req.word0_zero ? rel_pc : seq_pc;
      end
      op_brhz: begin
        res_d.taken   = iss_req.half1_zero;
        res_d.next_pc = iss_req.half1_zero ? rel_pc : seq_pc;
      end
      op_brhnz: begin
        res_d.taken   = !iss_req.half1_zero;
        res_d.next_pc = !iss_req.half1_zero ? rel_pc : seq_pc;
      end
      default: begin
        res_d = '0;  // not taken, pc 0, no link
      end
    endcase
  end

  // ********************************************************************
  // result register
  // ********************************************************************

  assign iss_ready = !alu_valid || alu_ready;
  assign iss_fire  = iss_valid && iss_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      alu_valid <= 1'b0;
    end else if (iss_ready) begin
      alu_valid <= iss_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (iss_fire) begin
      alu_res <= res_d;
    end
  end

endmodule

//--- branch_issue.sv
`timescale 1ns/10ps

module branch_issue (
  input  logic                       clk,
  input  logic                       reset,

  input  logic                       in_valid,
  output logic                       in_ready,
  input  spu_branch_pkg::branch_req_t in_req,

  output logic                       iss_valid,
  input  logic                       iss_ready,
  output spu_branch_pkg::issue_req_t  iss_req
);

  import spu_branch_pkg::*;

  logic       in_fire;
  issue_req_t req_d;
  logic       word0_zero;
  logic       half1_zero;

  // ********************************************************************
  // slot flags
  // ********************************************************************

  // preferred slot tests, done once here
  assign word0_zero = (in_req.rt_data[0:word_width-1] == '0);
  assign half1_zero = (in_req.rt_data[word_width/2:word_width-1] == '0);

  always_comb begin
    req_d.req        = in_req;
    req_d.word0_zero = word0_zero;
    req_d.half1_zero = half1_zero;
  end

  // ********************************************************************
  // one-entry pipeline register
  // ********************************************************************

  assign in_ready = !iss_valid || iss_ready;  // empty or draining
  assign in_fire  = in_valid && in_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      iss_valid <= 1'b0;
    end else if (in_ready) begin
      iss_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_fire) begin
      iss_req <= req_d;
    end
  end

endmodule

//--- branch_redirect.sv
`timescale 1ns/10ps

module branch_redirect #(
  parameter int depth = 2
) (
  input  logic                        clk,
  input  logic                        reset,

  input  logic                        alu_valid,
  output logic                        alu_ready,
  input  spu_branch_pkg::branch_res_t  alu_res,

  output logic                        out_valid,
  input  logic                        out_ready,
  output spu_branch_pkg::branch_res_t  out_res
);

  import spu_branch_pkg::*;

  localparam int ptr_width = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_width = $clog2(depth + 1);

  branch_res_t          mem [0:depth-1];
  logic [0:ptr_width-1] wr_ptr;
  logic [0:ptr_width-1] rd_ptr;
  logic [0:cnt_width-1] count;
  logic                 fresh_q;  // tail written on last edge
  logic                 full;
  logic                 wr_en;
  logic                 rd_en;

  assign full      = (count == cnt_width'(depth));
  assign out_valid = (count != '0) && !((count == cnt_width'(1)) && fresh_q);
  assign rd_en     = out_valid && out_ready;
  assign alu_ready = !full || rd_en;  // head leaving frees a slot
  assign wr_en     = alu_valid && alu_ready;
  assign out_res   = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= alu_res;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      fresh_q <= 1'b0;
    end else begin
      fresh_q <= wr_en;
      if (wr_en) begin
        wr_ptr <= (wr_ptr == ptr_width'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= (rd_ptr == ptr_width'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // idle or pass-through
      endcase
    end
  end

endmodule

//--- branch_unit_top.sv
`timescale 1ns/10ps

module branch_unit_top #(
  parameter int redirect_depth = 2
) (
  input  logic                        clk,
  input  logic                        reset,

  input  logic                        in_valid,
  output logic                        in_ready,
  input  spu_branch_pkg::branch_req_t  in_req,

  output logic                        out_valid,
  input  logic                        out_ready,
  output spu_branch_pkg::branch_res_t  out_res
);

  import spu_branch_pkg::*;

  // ********************************************************************
  // stage links
  // ********************************************************************

  logic        iss_valid;
  logic        iss_ready;
  issue_req_t  iss_req;
  logic        alu_valid;
  logic        alu_ready;
  branch_res_t alu_res;

  branch_issue issue_inst (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_req    (in_req),
    .iss_valid (iss_valid),
    .iss_ready (iss_ready),
    .iss_req   (iss_req)
  );

  branch_alu alu_inst (
    .clk       (clk),
    .reset     (reset),
    .iss_valid (iss_valid),
    .iss_ready (iss_ready),
    .iss_req   (iss_req),
    .alu_valid (alu_valid),
    .alu_ready (alu_ready),
    .alu_res   (alu_res)
  );

  branch_redirect #(
    .depth     (redirect_depth)
  ) redirect_inst (
    .clk       (clk),
    .reset     (reset),
    .alu_valid (alu_valid),
    .alu_ready (alu_ready),
    .alu_res   (alu_res),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_res   (out_res)
  );

endmodule

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run, and look for the fail message in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing -f verilog.f --top-module tb_branch_unit \
  -o sim_branch_unit > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_branch_unit > sim.log 2>&1 \
  || { cat sim.log; echo "simulation did not complete"; exit 1; }
cat sim.log
grep -q "TEST FAILED" sim.log && { echo "simulation failed"; exit 1; }
echo "simulation passed"
exit 0

//--- spu_branch_pkg.sv
package spu_branch_pkg;

  // ********************************************************************
  // widths, ascending bit order (bit 0 is the msb)
  // ********************************************************************

  localparam int pc_width   = 10;   // word-addressed local store
  localparam int imm_width  = 16;
  localparam int data_width = 128;  // one simd register
  localparam int word_width = 32;   // preferred slot
  localparam int op_width   = 7;    // same width as instr_id

  // ********************************************************************
  // branch opcodes
  // ********************************************************************

  typedef enum logic [0:op_width-1] {
    op_br    = 7'h10,  // relative
    op_bra   = 7'h11,  // absolute
    op_brsl  = 7'h12,  // relative, link
    op_brasl = 7'h13,  // absolute, link
    op_brz   = 7'h14,
    op_brnz  = 7'h15,
    op_brhz  = 7'h16,
    op_brhnz = 7'h17
  } branch_op_e;

  // ********************************************************************
  // request and result records
  // ********************************************************************

  typedef struct packed {
    branch_op_e              op;
    logic [0:pc_width-1]     pc;
    logic [0:imm_width-1]    imm16;
    logic [0:data_width-1]   rt_data;
  } branch_req_t;

  typedef struct packed {
    logic                    taken;
    logic [0:pc_width-1]     next_pc;
    logic                    link;       // brsl and brasl only
    logic [0:data_width-1]   link_data;  // value for rt
  } branch_res_t;

  // request plus slot flags formed at issue
  typedef struct packed {
    branch_req_t             req;
    logic                    word0_zero;  // bits 0 to 31
    logic                    half1_zero;  // bits 16 to 31
  } issue_req_t;

endpackage

//--- tb_branch_unit.sv
`timescale 1ns/10ps

module tb_branch_unit;

  import spu_branch_pkg::*;

  localparam int clk_period      = 4;
  localparam int n_requests      = 8 + 6 + 8 + 8 + 40 + 4 + 2;
  localparam int watchdog_cycles = n_requests * 20 + 2 * 8 + 100;

  logic        clk;
  logic        reset;
  logic        in_valid;
  logic        in_ready;
  branch_req_t in_req;
  logic        out_valid;
  logic        out_ready;
  branch_res_t out_res;

  branch_res_t exp_q [$];           // results still owed by the DUT
  logic [31:0] lfsr = 32'h6e8;
  logic        random_ready;        // out_ready from the lfsr
  logic        hold_ready;          // out_ready forced low
  int          cycles = 0;
  int          acc_cycle;
  int          out_cycle;
  int          recv_count = 0;
  int          check_count = 0;
  int          error_count = 0;
  int          errors_at_start = 0;

  branch_unit_top #(
    .redirect_depth (2)
  ) uut (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_req    (in_req),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_res   (out_res)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  always @(posedge clk) cycles <= cycles + 1;

  initial begin
    #(watchdog_cycles * clk_period);
    $display("watchdog expired, the run hung with %0d results outstanding", exp_q.size());
    $display("TEST FAILED");
    $finish;
  end

  // ********************************************************************
  // helpers
  // ********************************************************************

  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] val;
    logic        fb;
    int          i;
    val = '0;
    for (i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];  // x^32+x^22+x^2+x+1
      lfsr = {lfsr[30:0], fb};
      val  = {val[30:0], fb};
    end
    return val;
  endfunction

  function automatic logic [0:data_width-1] random_data();
    logic [127:0] d;
    int           w;
    d = '0;
    for (w = 0; w < 4; w++) begin
      d = {d[95:0], random_bits(32)};
    end
    return d;
  endfunction

  task automatic check(input string name, input logic [127:0] got, input logic [127:0] want);
    check_count++;
    if (got !== want) begin
      error_count++;
      $display("Mismatch %s: got %h expected %h", name, got, want);
    end
  endtask

  // expected result from the branch rules
  task automatic predict(input branch_req_t r, output branch_res_t e);
    logic [31:0] word0;
    logic [9:0]  seq_pc;
    logic [9:0]  target;
    logic        taken;
    logic        known;
    word0  = 32'(r.rt_data >> 96);
    seq_pc = 10'((int'(r.pc) + 1) % 1024);
    target = 10'((int'(r.pc) + int'(r.imm16) % 1024) % 1024);  // relative
    taken  = 1'b0;
    known  = 1'b1;
    case (r.op)
      op_br, op_brsl:   taken = 1'b1;
      op_bra, op_brasl: begin
        taken  = 1'b1;
        target = 10'(int'(r.imm16) % 1024);
      end
      op_brz:   taken = (word0 == 32'd0);
      op_brnz:  taken = (word0 != 32'd0);
      op_brhz:  taken = (word0[15:0] == 16'd0);
      op_brhnz: taken = (word0[15:0] != 16'd0);
      default:  known = 1'b0;
    endcase
    e = '0;
    if (known) begin
      e.taken   = taken;
      e.next_pc = taken ? target : seq_pc;
    end
    if (r.op == op_brsl || r.op == op_brasl) begin
      e.link      = 1'b1;
      e.link_data = 128'(seq_pc) << 96;  // low bits of word 0
    end
  endtask

  // drive at the falling edge, look at both handshakes 1 ns later
  task automatic cycle(input logic valid, input branch_req_t req, output logic accepted);
    branch_res_t want;
    @(negedge clk);
    in_valid  = valid;
    in_req    = req;
    out_ready = hold_ready ? 1'b0 : (random_ready ? (random_bits(1) != 32'd0) : 1'b1);
    #1;
    if (out_valid && out_ready) begin
      recv_count++;
      out_cycle = cycles;
      if (exp_q.size() == 0) begin
        error_count++;
        $display("unexpected result at cycle %0d with nothing outstanding", cycles);
      end else begin
        want = exp_q.pop_front();
        check("taken", 128'(out_res.taken), 128'(want.taken));
        check("next_pc", 128'(out_res.next_pc), 128'(want.next_pc));
        check("link", 128'(out_res.link), 128'(want.link));
        check("link_data", out_res.link_data, want.link_data);
      end
    end
    accepted = in_valid && in_ready;
    if (accepted) begin
      predict(req, want);
      exp_q.push_back(want);
      acc_cycle = cycles + 1;  // edge that takes it
    end
  endtask

  task automatic send(input branch_op_e op, input logic [0:pc_width-1] pc,
                      input logic [0:imm_width-1] imm, input logic [0:data_width-1] data);
    branch_req_t req;
    logic        acc;
    req.op      = op;
    req.pc      = pc;
    req.imm16   = imm;
    req.rt_data = data;
    acc = 1'b0;
    while (!acc) cycle(1'b1, req, acc);
  endtask

  task automatic drain();
    logic acc;
    while (exp_q.size() != 0) cycle(1'b0, '0, acc);
  endtask

  task automatic apply_reset();
    logic acc;
    @(negedge clk);
    reset    = 1'b1;
    in_valid = 1'b0;
    repeat (7) cycle(1'b0, '0, acc);
    @(negedge clk);
    reset = 1'b0;
  endtask

  task automatic end_test(input string name);
    $display("test %-16s %0d errors", name, error_count - errors_at_start);
    errors_at_start = error_count;
  endtask

  // ********************************************************************
  // tests
  // ********************************************************************

  task automatic test_unconditional();
    logic [0:pc_width-1]  pcs [4];
    logic [0:imm_width-1] imms [4];
    int                   i;
    int                   j;
    pcs  = '{10'd1023, 10'd1022, 10'd1000, 10'd3};
    imms = '{16'h0001, 16'h03ff, 16'h8030, 16'hfffe};
    for (i = 0; i < 4; i++) begin
      for (j = 0; j < 2; j++) begin
        send((j == 0) ? op_br : op_bra, pcs[i], imms[i], random_data());
        drain();
        check("latency", 128'(out_cycle - acc_cycle), 128'(3));
      end
    end
    end_test("unconditional");
  endtask

  task automatic test_link();
    logic [0:pc_width-1] pcs [3];
    int                  i;
    pcs = '{10'd1023, 10'd511, 10'd0};
    for (i = 0; i < 3; i++) begin
      send(op_brsl, pcs[i], 16'(random_bits(16)), random_data());
      send(op_brasl, pcs[i], 16'(random_bits(16)), random_data());
    end
    drain();
    end_test("link");
  endtask

  task automatic test_word_cond();
    logic [0:data_width-1] zero_w0;
    logic [0:data_width-1] set_w0;
    zero_w0 = {32'h0000_0000, 32'hffff_ffff, 32'h1234_5678, 32'h0000_0001};
    set_w0  = {32'h0000_0200, 32'hffff_ffff, 32'h1234_5678, 32'h0000_0001};
    send(op_brz, 10'd1023, 16'h0010, zero_w0);
    send(op_brz, 10'd1023, 16'h0010, set_w0);
    send(op_brz, 10'd100, 16'hfff0, zero_w0);
    send(op_brz, 10'd100, 16'hfff0, set_w0);
    send(op_brnz, 10'd1023, 16'h0010, zero_w0);
    send(op_brnz, 10'd1023, 16'h0010, set_w0);
    send(op_brnz, 10'd100, 16'hfff0, zero_w0);
    send(op_brnz, 10'd100, 16'hfff0, set_w0);
    drain();
    end_test("word conditional");
  endtask

  task automatic test_half_cond();
    logic [0:data_width-1] hi_only;
    logic [0:data_width-1] lo_only;
    hi_only = {32'habcd_0000, 32'h0000_0001, 32'h0000_0002, 32'h0000_0003};
    lo_only = {32'h0000_abcd, 32'h0000_0001, 32'h0000_0002, 32'h0000_0003};
    send(op_brhz, 10'd1020, 16'h0008, hi_only);
    send(op_brhz, 10'd1020, 16'h0008, lo_only);
    send(op_brhz, 10'd7, 16'h03fe, hi_only);
    send(op_brhz, 10'd7, 16'h03fe, lo_only);
    send(op_brhnz, 10'd1020, 16'h0008, hi_only);
    send(op_brhnz, 10'd1020, 16'h0008, lo_only);
    send(op_brhnz, 10'd7, 16'h03fe, hi_only);
    send(op_brhnz, 10'd7, 16'h03fe, lo_only);
    drain();
    end_test("half conditional");
  endtask

  task automatic test_backpressure();
    branch_op_e            ops [8];
    logic [0:data_width-1] d;
    int                    base;
    int                    i;
    ops  = '{op_br, op_bra, op_brsl, op_brasl, op_brz, op_brnz, op_brhz, op_brhnz};
    base = recv_count;
    random_ready = 1'b1;
    for (i = 0; i < 40; i++) begin
      d = random_data();
      if (random_bits(1) != 32'd0) begin
        d[0:31] = '0;
      end else if (random_bits(1) != 32'd0) begin
        d[16:31] = '0;
      end
      send(ops[3'(random_bits(3))], 10'(random_bits(10)), 16'(random_bits(16)), d);
    end
    drain();
    random_ready = 1'b0;
    check("result_count", 128'(recv_count - base), 128'(40));
    end_test("backpressure");
  endtask

  task automatic test_reset_unknown();
    logic acc;
    int   i;
    // fill every stage, then reset with results still queued
    hold_ready = 1'b1;
    for (i = 0; i < 4; i++) begin
      send(op_br, 10'(i), 16'h0005, random_data());
    end
    apply_reset();
    exp_q.delete();
    hold_ready = 1'b0;
    cycle(1'b0, '0, acc);
    check("out_valid", 128'(out_valid), 128'(0));
    check("in_ready", 128'(in_ready), 128'(1));
    send(branch_op_e'(7'h00), 10'd77, 16'h0123, random_data());
    send(branch_op_e'(7'h7f), 10'd1023, 16'hffff, random_data());
    drain();
    end_test("reset unknown");
  endtask

  initial begin
    reset        = 1'b1;
    in_valid     = 1'b0;
    in_req       = '0;
    out_ready    = 1'b1;
    random_ready = 1'b0;
    hold_ready   = 1'b0;
    apply_reset();
    test_unconditional();
    test_link();
    test_word_cond();
    test_half_cond();
    test_backpressure();
    test_reset_unknown();
    $display("6 tests, %0d checks, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- verilog.f
spu_branch_pkg.sv
branch_issue.sv
branch_alu.sv
branch_redirect.sv
branch_unit_top.sv
tb_branch_unit.sv
